/* run_sim.sh */
#!/bin/sh
# build and run the z3sdram testbench with Verilator, run from the project root
verilator --binary --timing --assert -f z3sdram.f --top-module z3sdram_tb -o z3sim \
	&& out=$(./obj_dir/z3sim) \
	; echo "$out" \
	&& echo "$out" | grep -qx "PASS: all tests" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* sim/z3sdram_patterns.txt */
# op(0 rd,1 wr,2 rd held,3 reset) fc addr data nds exp_data resp(0 none,1 dtack,2 fault)
# ROM reads before configuration
0 1 FF000000 00000000 0 AFFFFFFF 1
0 1 FF000004 00000000 0 0FFFFFFF 1
0 2 FF000008 00000000 0 FFFFFFFF 1
0 1 FF00000C 00000000 0 EFFFFFFF 1
0 1 FF000010 00000000 0 CFFFFFFF 1
0 1 FF000014 00000000 0 BFFFFFFF 1
0 1 FF000020 00000000 0 FFFFFFFF 1
0 1 FF000024 00000000 0 8FFFFFFF 1
0 1 FF000028 00000000 0 2FFFFFFF 1
0 1 FF00002C 00000000 0 4FFFFFFF 1
0 1 FF00003C 00000000 0 EFFFFFFF 1
0 1 FF000050 00000000 0 FFFFFFFF 1
# wrong function code or no space
0 0 FF000000 00000000 0 00000000 0
0 3 FF000004 00000000 0 00000000 0
0 1 12000000 00000000 0 00000000 0
0 1 40000010 00000000 0 00000000 0
# base write, card at 4000_0000
1 1 FF000044 00004000 0 00000000 1
0 1 FF000000 00000000 0 00000000 0
# card writes and reads
1 1 40000010 11223344 0 00000000 1
1 1 40000020 A5A5F00F 0 00000000 1
1 2 40123450 DEADBEEF 0 00000000 1
1 1 43FFFFFC 01234567 0 00000000 1
0 1 40000010 00000000 0 11223344 1
0 1 40000020 00000000 0 A5A5F00F 1
0 2 40123450 00000000 0 DEADBEEF 1
0 1 43FFFFFC 00000000 0 01234567 1
# byte lanes
1 1 40000010 9999BEEF C 00000000 1
0 1 40000010 00000000 0 1122BEEF 1
1 1 40000020 77000000 7 00000000 1
0 1 40000020 00000000 0 77A5F00F 1
# stuck cycle, then a clean cycle clears the fault
2 1 40123450 00000000 0 DEADBEEF 2
0 1 43FFFFFC 00000000 0 01234567 1
0 1 44000000 00000000 0 00000000 0
# fresh reset, shut up
3 0 00000000 00000000 0 00000000 0
1 1 FF00004C 00000000 0 00000000 1
0 1 FF000000 00000000 0 00000000 0
0 1 40000010 00000000 0 00000000 0

/* sim/z3sdram_props.sv */
// bus protocol properties for the slave core top level, attached to z3sdram by bind
`timescale 1ns/1ps

module z3sdram_props (
	input logic clk,
	input logic nIORST,
	input logic nfcs_i,
	input logic read_i,
	input logic nslave_o,
	input logic ndtack_o,
	input logic data_oe_o,
	input logic mem_stb_o
);

	// ----------------------------------------------------------
	// slave select only inside a bus cycle
	a_slave_in_cycle: assert property (@(posedge clk) disable iff (!nIORST)
		nfcs_i |-> nslave_o)
		else $error("nslave_o low while nfcs_i is high");

	// DTACK only from a selected slave
	a_dtack_selected: assert property (@(posedge clk) disable iff (!nIORST)
		!ndtack_o |-> !nslave_o)
		else $error("ndtack_o low without nslave_o");

	// data lanes driven on reads only
	a_oe_read: assert property (@(posedge clk) disable iff (!nIORST)
		data_oe_o |-> read_i)
		else $error("data_oe_o high on a write cycle");

	// memory strobe is a single cycle pulse
	a_stb_pulse: assert property (@(posedge clk) disable iff (!nIORST)
		mem_stb_o |=> !mem_stb_o)
		else $error("mem_stb_o held for two cycles");

endmodule

/* sim/z3sdram_tb.sv */
// testbench for the zorro 3 slave core that replays the bus cycles of the patterns file
`timescale 1ns/1ps

module z3sdram_tb;

	logic        clk;
	logic        nIORST;
	logic        nfcs_i;
	logic        doe_i;
	logic        read_i;
	logic [3:0]  nds_i;
	logic [1:0]  fc_i;
	logic [23:0] ad_i;
	logic [5:0]  a_i;
	logic [7:0]  sd_i;
	logic        nberr_i;
	logic        ncfgin_i;
	logic        nslave_o;
	logic        ndtack_o;
	logic        data_oe_o;
	logic [23:0] ad_o;
	logic [7:0]  sd_o;
	logic        ncfgout_o;
	logic        fault_o;
	logic        mem_stb_o;
	logic        mem_we_o;
	logic [23:0] mem_addr_o;
	logic [31:0] mem_wdata_o;
	logic [3:0]  mem_dqm_n_o;
	logic [31:0] mem_rdata_i;
	logic        mem_ack_i;

	// memory model state
	logic [31:0] mem [0:255];
	logic [16:0] lfsr;
	logic        pend;
	logic [3:0]  ack_cnt;
	logic [7:0]  pend_idx;
	logic        pend_we;
	logic [31:0] pend_wdata;
	logic [3:0]  pend_dqm;
	// current cycle kept for checking the memory port
	logic [31:0] cur_addr;
	logic [31:0] cur_data;
	logic [3:0]  cur_nds;
	logic        cur_read;
	logic        exp_ncfgout;

	z3sdram uut (.*);

	bind z3sdram z3sdram_props u_props (
		.clk       (clk),
		.nIORST    (nIORST),
		.nfcs_i    (nfcs_i),
		.read_i    (read_i),
		.nslave_o  (nslave_o),
		.ndtack_o  (ndtack_o),
		.data_oe_o (data_oe_o),
		.mem_stb_o (mem_stb_o)
	);

	initial clk = 1'b0;
	always #10 clk = ~clk;

	// ----------------------------------------------------------
	// reporting
	task automatic stop_run(input string msg);
		$display("%s at %0t", msg, $time);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic check_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		lfsr_next = {s[15:0], s[16] ^ s[13]};
	endfunction

	// ----------------------------------------------------------
	// memory model with one request at a time and an ack after 1 to 8 cycles
	always @(posedge clk) begin
		mem_ack_i <= 1'b0;
		if (mem_stb_o) begin
			if (pend)
				stop_run("memory strobe while a request is still open");
			check_equal("mem_addr_o", 32'(mem_addr_o), 32'(cur_addr[25:2]));
			check_equal("mem_we_o", 32'(mem_we_o), 32'(!cur_read));
			if (!cur_read) begin
				check_equal("mem_dqm_n_o", 32'(mem_dqm_n_o), 32'(cur_nds));
				check_equal("mem_wdata_o", mem_wdata_o, cur_data);
			end
			pend       = 1'b1;
			pend_idx   = mem_addr_o[7:0];
			pend_we    = mem_we_o;
			pend_wdata = mem_wdata_o;
			pend_dqm   = mem_dqm_n_o;
			// three bits with one LFSR step each
			ack_cnt = 4'd1;
			for (int i = 0; i < 3; i++) begin
				lfsr    = lfsr_next(lfsr);
				ack_cnt = ack_cnt + 4'({3'b000, lfsr[16]} << i);
			end
		end else if (pend) begin
			ack_cnt = ack_cnt - 4'd1;
			if (ack_cnt == 4'd0) begin
				pend = 1'b0;
				if (pend_we) begin
					// dqm low enables a lane
					// bit 3 is D31..24
					for (int b = 0; b < 4; b++)
						if (!pend_dqm[b])
							mem[pend_idx][8*b +: 8] = pend_wdata[8*b +: 8];
				end
				mem_rdata_i <= mem[pend_idx];
				mem_ack_i   <= 1'b1;
			end
		end
	end

	// ----------------------------------------------------------
	// bus master
	task automatic apply_reset();
		@(posedge clk);
		nIORST <= 1'b0;
		repeat (5) @(posedge clk);
		nIORST <= 1'b1;
		exp_ncfgout = 1'b1;
		@(posedge clk);
	endtask

	task automatic end_cycle();
		@(posedge clk);
		nfcs_i <= 1'b1;
		doe_i  <= 1'b0;
		nds_i  <= 4'hF;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_equal("nslave_o after cycle", 32'(nslave_o), 32'd1);
		check_equal("ndtack_o after cycle", 32'(ndtack_o), 32'd1);
	endtask

	// op is 0 read or 1 write or 2 read held past DTACK
	// resp is 0 none or 1 dtack or 2 fault
	task automatic bus_cycle(input logic [31:0] op, input logic [1:0] fc,
		input logic [31:0] addr, input logic [31:0] data, input logic [3:0] nds,
		input logic [31:0] exp_data, input logic [31:0] resp);
		int n;
		cur_addr = addr;
		cur_data = data;
		cur_nds  = nds;
		cur_read = (op != 32'd1);
		@(posedge clk);
		nfcs_i <= 1'b0;
		fc_i   <= fc;
		read_i <= cur_read;
		ad_i   <= addr[31:8];
		a_i    <= addr[7:2];
		// address held two cycles after FCS falls
		repeat (2) @(posedge clk);
		if (!cur_read) begin
			ad_i <= {data[31:24], data[15:0]};
			sd_i <= data[23:16];
		end
		doe_i <= 1'b1;
		@(posedge clk);
		nds_i <= nds;
		if (resp == 32'd0) begin
			// nobody may answer
			repeat (10) begin
				@(negedge clk);
				check_equal("nslave_o on foreign cycle", 32'(nslave_o), 32'd1);
			end
		end else begin
			n = 0;
			@(negedge clk);
			while (ndtack_o) begin
				n++;
				if (n > 40)
					stop_run("timeout waiting for ndtack_o");
				@(negedge clk);
			end
			check_equal("nslave_o at dtack", 32'(nslave_o), 32'd0);
			check_equal("data_oe_o at dtack", 32'(data_oe_o), 32'(cur_read));
			if (cur_read)
				check_equal("read data", {ad_o[23:16], sd_o, ad_o[15:0]}, exp_data);
			if (resp == 32'd2) begin
				// keep FCS low until the stuck cycle detector fires
				n = 0;
				while (!fault_o) begin
					n++;
					if (n > 80)
						stop_run("timeout waiting for fault_o");
					@(negedge clk);
				end
				// 48 cycles in dtack before dtack_err
				check_equal("cycles in dtack before fault", 32'(n), 32'd48);
				check_equal("ndtack_o after fault", 32'(ndtack_o), 32'd1);
			end
			check_equal("fault_o", 32'(fault_o), 32'(resp == 32'd2));
			// base and shut-up writes pass the chain on
			if (!cur_read && addr[31:16] == 16'hFF00 &&
				(addr[8:2] == 7'h11 || addr[8:2] == 7'h13))
				exp_ncfgout = 1'b0;
		end
		end_cycle();
		check_equal("ncfgout_o", 32'(ncfgout_o), 32'(exp_ncfgout));
	endtask

	// ----------------------------------------------------------
	// main sequence
	initial begin
		int fd;
		int cnt;
		string line;
		logic [31:0] f_op;
		logic [31:0] f_fc;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_nds;
		logic [31:0] f_exp;
		logic [31:0] f_resp;
		nIORST      = 1'b0;
		nfcs_i      = 1'b1;
		doe_i       = 1'b0;
		read_i      = 1'b1;
		nds_i       = 4'hF;
		fc_i        = 2'b01;
		ad_i        = 24'h0;
		a_i         = 6'h0;
		sd_i        = 8'h0;
		nberr_i     = 1'b1;
		ncfgin_i    = 1'b0;
		mem_ack_i   = 1'b0;
		mem_rdata_i = 32'h0;
		lfsr        = 17'd93516;
		pend        = 1'b0;
		ack_cnt     = 4'd0;
		exp_ncfgout = 1'b1;
		// fill from the whole word index
		for (int i = 0; i < 256; i++)
			mem[i] = {4{8'(i)}} ^ 32'h5A5A5A5A;
		apply_reset();
		check_equal("ncfgout_o after reset", 32'(ncfgout_o), 32'd1);
		check_equal("mem_stb_o after reset", 32'(mem_stb_o), 32'd0);
		fd = $fopen("sim/z3sdram_patterns.txt", "r");
		if (fd == 0)
			stop_run("cannot open the patterns file");
		while (!$feof(fd)) begin
			line = "";
			cnt = $fgets(line, fd);
			if (cnt > 1 && line.getc(0) != "#") begin
				cnt = $sscanf(line, "%h %h %h %h %h %h %h",
					f_op, f_fc, f_addr, f_data, f_nds, f_exp, f_resp);
				if (cnt != 7)
					stop_run("malformed line in the patterns file");
				if (f_op == 32'd3)
					apply_reset();
				else
					bus_cycle(f_op, f_fc[1:0], f_addr, f_data, f_nds[3:0], f_exp, f_resp);
			end
		end
		$fclose(fd);
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* source/z3_autoconfig.sv */
// zorro 3 autoconfig registers, config ROM, base address, shut-up and the config chain
`timescale 1ns/1ps
`include "z3_consts.svh"

module z3_autoconfig import z3_pkg::*; (
	input  logic       clk,
	input  logic       nIORST,
	input  logic       ncfgin_i,
	input  logic       cfg_wr_i,
	input  logic       read_i,
	z3_cycle_if.cfg    cyc,
	output z3_nibble_t cfg_rdata_o,
	output logic [`Z3_CARD_MATCH_BITS-1:0] base_hi_o,
	output logic       card_en_o,
	output logic       cfg_allow_o,
	output logic       ncfgout_o
);

	logic [`Z3_REG_IDX_W-1:0]      reg_idx;
	logic                          wr_ok;
	logic                          configured;
	logic                          shutup;
	logic [`Z3_CARD_MATCH_BITS-1:0] base_q;

	// register index from A8..A2
	assign reg_idx = cyc.addr[`Z3_REG_IDX_W+1:2];

	// ----------------------------------------------------------
	// config ROM
	always_comb begin
		case (reg_idx)
			7'd0:    cfg_rdata_o = `Z3_ROM_N0;
			7'd1:    cfg_rdata_o = `Z3_ROM_N1;
			7'd2:    cfg_rdata_o = `Z3_ROM_N2;
			7'd3:    cfg_rdata_o = `Z3_ROM_N3;
			7'd4:    cfg_rdata_o = `Z3_ROM_N4;
			7'd5:    cfg_rdata_o = `Z3_ROM_N5;
			7'd6:    cfg_rdata_o = `Z3_ROM_N6;
			7'd7:    cfg_rdata_o = `Z3_ROM_N7;
			7'd8:    cfg_rdata_o = `Z3_ROM_N8;
			7'd9:    cfg_rdata_o = `Z3_ROM_N9;
			7'd10:   cfg_rdata_o = `Z3_ROM_N10;
			7'd11:   cfg_rdata_o = `Z3_ROM_N11;
			7'd12:   cfg_rdata_o = `Z3_ROM_N12;
			7'd13:   cfg_rdata_o = `Z3_ROM_N13;
			7'd14:   cfg_rdata_o = `Z3_ROM_N14;
			7'd15:   cfg_rdata_o = `Z3_ROM_N15;
			// unused registers read as all ones
			default: cfg_rdata_o = 4'hF;
		endcase
	end

	// ----------------------------------------------------------
	// register writes
	// write strobe from the FSM, still in config space, some byte lane active
	assign wr_ok = cfg_wr_i & cyc.cfg_hit & ~read_i & (cyc.nds_s != 4'hF);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			configured <= 1'b0;
			shutup     <= 1'b0;
		end else if (wr_ok) begin
			if (reg_idx == `Z3_REG_BASE_HI)
				configured <= 1'b1;
			if (reg_idx == `Z3_REG_SHUTUP)
				shutup <= 1'b1;
		end
	end

	// base address, A31..A26 of the card space
	always_ff @(posedge clk) begin
		if (wr_ok & (reg_idx == `Z3_REG_BASE_HI))
			base_q <= cyc.wdata[15:10];
	end

	assign base_hi_o = base_q;

	// ----------------------------------------------------------
	// space enables and chain
	assign card_en_o   = configured & ~shutup;
	// config space only while unconfigured and our turn in the chain
	assign cfg_allow_o = ~configured & ~shutup & ~ncfgin_i;
	// pass the chain on once configured or shut up
	assign ncfgout_o   = ~(configured | shutup);

endmodule

/* source/z3_bus_sampler.sv */
// samples the zorro 3 strobes, latches the cycle address and write word, decodes the spaces
`timescale 1ns/1ps
`include "z3_consts.svh"

module z3_bus_sampler import z3_pkg::*; (
	input  logic       clk,
	input  logic       nIORST,
	input  logic       nfcs_i,
	input  logic       doe_i,
	input  logic [3:0] nds_i,
	input  logic [1:0] fc_i,
	input  logic [23:0] ad_i,
	input  logic [5:0] a_i,
	input  logic [7:0] sd_i,
	input  logic [`Z3_CARD_MATCH_BITS-1:0] base_hi_i,
	input  logic       card_en_i,
	input  logic       cfg_allow_i,
	z3_cycle_if.sampler cyc
);

	logic [3:0] nds_q1;
	logic       fc_ok;
	logic       fcs_low;
	logic       cfg_match;
	logic       card_match;

	// ----------------------------------------------------------
	// strobe synchronizers
	// FCS and DOE one stage, nDS two
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cyc.fcs_n_s <= 1'b1;
			cyc.doe_s   <= 1'b0;
			nds_q1      <= 4'hF;
			cyc.nds_s   <= 4'hF;
		end else begin
			cyc.fcs_n_s <= nfcs_i;
			cyc.doe_s   <= doe_i;
			nds_q1      <= nds_i;
			cyc.nds_s   <= nds_q1;
		end
	end

	// ----------------------------------------------------------
	// address and write data capture
	always_ff @(posedge clk) begin
		// first edge with FCS low, AD still holds the address
		if (~nfcs_i & cyc.fcs_n_s)
			cyc.addr <= {ad_i, a_i, 2'b00};
		// keep following the bus until a data strobe shows up
		// D31..24 on AD31..24, D23..16 on SD, D15..0 on AD23..8
		if (&nds_q1)
			cyc.wdata <= {ad_i[23:16], sd_i, ad_i[15:0]};
	end

	// ----------------------------------------------------------
	// space decode
	// only data and program spaces, FC0 != FC1
	assign fc_ok   = fc_i[0] ^ fc_i[1];
	// FCS low now and on the previous edge, so addr is this cycle's
	assign fcs_low = ~nfcs_i & ~cyc.fcs_n_s;

	assign cfg_match  = cfg_allow_i & (cyc.addr[`Z3_ADDR_W-1 -: 16] == `Z3_CFG_BASE);
	assign card_match = card_en_i &
		(cyc.addr[`Z3_ADDR_W-1 -: `Z3_CARD_MATCH_BITS] == base_hi_i);

	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cyc.cfg_hit  <= 1'b0;
			cyc.card_hit <= 1'b0;
		end else begin
			cyc.cfg_hit  <= fcs_low & fc_ok & cfg_match;
			cyc.card_hit <= fcs_low & fc_ok & card_match;
		end
	end

endmodule

/* source/z3_consts.svh */
// shared widths, space codes, config ROM and timing constants, included by the RTL files
`ifndef Z3_CONSTS_SVH
`define Z3_CONSTS_SVH

// ----------------------------------------------------------
// widths
`define Z3_ADDR_W           32
`define Z3_DATA_W           32
// word address on the memory port, address bits 25..2
`define Z3_MEM_ADDR_W       24
// config register index, address bits 8..2
`define Z3_REG_IDX_W        7

// ----------------------------------------------------------
// address spaces
`define Z3_CFG_BASE         16'hFF00
// high address bits compared against the base register
`define Z3_CARD_MATCH_BITS  6

// config register indices
`define Z3_REG_BASE_HI      7'h11
`define Z3_REG_SHUTUP       7'h13

// ----------------------------------------------------------
// config ROM, one nibble per index
// type: zorro 3, add to memory list
`define Z3_ROM_N0           4'hA
`define Z3_ROM_N1           4'h0
// product number, inverted
`define Z3_ROM_N2           4'hF
`define Z3_ROM_N3           4'hE
// flags, inverted
`define Z3_ROM_N4           4'hC
`define Z3_ROM_N5           4'hB
`define Z3_ROM_N6           4'hF
`define Z3_ROM_N7           4'hF
// manufacturer, inverted
`define Z3_ROM_N8           4'hF
`define Z3_ROM_N9           4'h8
`define Z3_ROM_N10          4'h2
`define Z3_ROM_N11          4'h4
// serial high byte, inverted
`define Z3_ROM_N12          4'hF
`define Z3_ROM_N13          4'hF
`define Z3_ROM_N14          4'hF
`define Z3_ROM_N15          4'hE

// cycles in dtack before the cycle counts as stuck
`define Z3_DTACK_TIMEOUT    48

`endif

/* source/z3_cycle_if.sv */
// sampled bus cycle, driven by the bus sampler, read by the slave FSM and autoconfig
`timescale 1ns/1ps

interface z3_cycle_if import z3_pkg::*; ();

	// latched cycle address and write word
	z3_word_t   addr;
	z3_word_t   wdata;
	// strobes in the clock domain
	logic       fcs_n_s;
	logic       doe_s;
	logic [3:0] nds_s;
	// registered decodes
	logic       cfg_hit;
	logic       card_hit;

	modport sampler (output addr, wdata, fcs_n_s, doe_s, nds_s, cfg_hit, card_hit);

	modport fsm (input addr, wdata, fcs_n_s, doe_s, nds_s, cfg_hit, card_hit);

	// autoconfig only needs the register index, data and strobes
	modport cfg (input addr, wdata, nds_s, cfg_hit);

endinterface

/* source/z3_pkg.sv */
// types shared by the zorro 3 slave core, imported by the modules that use them
`include "z3_consts.svh"

package z3_pkg;

	// ----------------------------------------------------------
	// slave cycle states
	// idle       waiting for a hit
	// match      slave selected, waiting for DOE
	// data       read pending or waiting for data strobes
	// write_stb  write handed to memory or config regs
	// write_wait waiting for the memory ack
	// dtack      cycle acknowledged, waiting for FCS to rise
	// dtack_err  master never ended the cycle
	typedef enum logic [2:0] {
		zs_idle       = 3'd0,
		zs_match      = 3'd1,
		zs_data       = 3'd2,
		zs_write_stb  = 3'd3,
		zs_write_wait = 3'd4,
		zs_dtack      = 3'd5,
		zs_dtack_err  = 3'd6
	} z3_state_t;

	// ----------------------------------------------------------
	// one bus word, D31..D0
	typedef logic [`Z3_DATA_W-1:0] z3_word_t;

	// one config ROM nibble, read back on D31..D28
	typedef logic [3:0] z3_nibble_t;

endpackage

/* source/z3_slave_fsm.sv */
// zorro 3 slave cycle FSM, drives slave select, DTACK, read data and the memory port
`timescale 1ns/1ps
`include "z3_consts.svh"

module z3_slave_fsm import z3_pkg::*; (
	input  logic       clk,
	input  logic       nIORST,
	input  logic       read_i,
	input  logic       nfcs_i,
	input  logic       nberr_i,
	input  logic       mem_ack_i,
	input  z3_word_t   mem_rdata_i,
	input  z3_nibble_t cfg_rdata_i,
	z3_cycle_if.fsm    cyc,
	output logic       nslave_o,
	output logic       ndtack_o,
	output logic       data_oe_o,
	output z3_word_t   rd_data_o,
	output logic       mem_stb_o,
	output logic       mem_we_o,
	output logic [`Z3_MEM_ADDR_W-1:0] mem_addr_o,
	output z3_word_t   mem_wdata_o,
	output logic [3:0] mem_dqm_n_o,
	output logic       cfg_wr_o,
	output logic       fault_o
);

	localparam int CNT_W = $clog2(`Z3_DTACK_TIMEOUT + 1);

	z3_state_t        state;
	z3_state_t        next;
	logic             cfg_cyc;
	logic             ack_seen;
	logic [CNT_W-1:0] dtack_cnt;
	logic             timeout;
	logic             enter_match;
	logic             start_rd;
	logic             start_wr;
	z3_word_t         rd_q;

	// ----------------------------------------------------------
	// state register
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST)
			state <= zs_idle;
		else
			state <= next;
	end

	assign timeout = (dtack_cnt == CNT_W'(`Z3_DTACK_TIMEOUT - 1));

	always_comb begin
		next = state;
		case (state)
			zs_idle:
				if ((cyc.cfg_hit | cyc.card_hit) & ~cyc.fcs_n_s)
					next = zs_match;
			zs_match:
				if (cyc.doe_s)
					next = zs_data;
			zs_data:
				if (read_i) begin
					// config reads answer at once, memory reads after the ack
					if (cfg_cyc | ack_seen)
						next = zs_dtack;
				end else if (cyc.nds_s != 4'hF) begin
					next = zs_write_stb;
				end
			zs_write_stb:
				next = cfg_cyc ? zs_dtack : zs_write_wait;
			zs_write_wait:
				if (ack_seen)
					next = zs_dtack;
			zs_dtack:
				if (timeout)
					next = zs_dtack_err;
			zs_dtack_err:
				next = zs_dtack_err;
			default:
				next = zs_idle;
		endcase
		// master ends every cycle by raising FCS
		if (nfcs_i)
			next = zs_idle;
	end

	assign enter_match = (state == zs_idle) & (next == zs_match);
	assign start_rd    = enter_match & cyc.card_hit & read_i;
	assign start_wr    = (state == zs_data) & (next == zs_write_stb) & ~cfg_cyc;

	// ----------------------------------------------------------
	// cycle flags
	always_ff @(posedge clk or negedge nIORST) begin
		if (!nIORST) begin
			cfg_cyc   <= 1'b0;
			ack_seen  <= 1'b0;
			mem_stb_o <= 1'b0;
			fault_o   <= 1'b0;
			dtack_cnt <= '0;
		end else begin
			// space is fixed for the whole cycle
			if (enter_match)
				cfg_cyc <= cyc.cfg_hit;
			// one request in flight, ack always comes after the strobe
			mem_stb_o <= start_rd | start_wr;
			if (start_rd | start_wr)
				ack_seen <= 1'b0;
			else if (mem_ack_i)
				ack_seen <= 1'b1;
			// stuck cycle detect
			if (state == zs_match)
				dtack_cnt <= '0;
			else if ((state == zs_dtack) & ~cyc.fcs_n_s & ~timeout)
				dtack_cnt <= dtack_cnt + 1'b1;
			if (enter_match)
				fault_o <= 1'b0;
			else if ((state == zs_dtack) & (next == zs_dtack_err))
				fault_o <= 1'b1;
		end
	end

	// ----------------------------------------------------------
	// memory request and read word
	always_ff @(posedge clk) begin
		if (start_rd | start_wr) begin
			mem_we_o    <= ~read_i;
			mem_addr_o  <= cyc.addr[`Z3_MEM_ADDR_W+1:2];
			mem_wdata_o <= cyc.wdata;
			mem_dqm_n_o <= cyc.nds_s;
		end
		if (mem_ack_i & ~mem_we_o)
			rd_q <= mem_rdata_i;
	end

	// config write pulse, one cycle in write_stb
	assign cfg_wr_o = (state == zs_write_stb) & cfg_cyc;

	// ROM nibble on D31..D28, ones below
	assign rd_data_o = cfg_cyc ? {cfg_rdata_i, {(`Z3_DATA_W - 4){1'b1}}} : rd_q;

	// ----------------------------------------------------------
	// bus outputs, all released as soon as FCS rises
	assign nslave_o  = nfcs_i | (state == zs_idle);
	assign ndtack_o  = nfcs_i | (state != zs_dtack);
	// drive data only on a selected read with no bus error
	assign data_oe_o = ~nfcs_i & ~nslave_o & cyc.doe_s & read_i & nberr_i;

endmodule

/* source/z3sdram.sv */
// zorro 3 memory card slave core, top level connecting sampler, FSM and autoconfig
`timescale 1ns/1ps
`include "z3_consts.svh"

module z3sdram import z3_pkg::*; (
	input  logic       clk,
	input  logic       nIORST,
	// zorro 3 bus
	input  logic       nfcs_i,
	input  logic       doe_i,
	input  logic       read_i,
	input  logic [3:0] nds_i,
	input  logic [1:0] fc_i,
	input  logic [23:0] ad_i,
	input  logic [5:0] a_i,
	input  logic [7:0] sd_i,
	input  logic       nberr_i,
	input  logic       ncfgin_i,
	output logic       nslave_o,
	output logic       ndtack_o,
	output logic       data_oe_o,
	output logic [23:0] ad_o,
	output logic [7:0] sd_o,
	output logic       ncfgout_o,
	output logic       fault_o,
	// memory port
	output logic       mem_stb_o,
	output logic       mem_we_o,
	output logic [`Z3_MEM_ADDR_W-1:0] mem_addr_o,
	output z3_word_t   mem_wdata_o,
	output logic [3:0] mem_dqm_n_o,
	input  z3_word_t   mem_rdata_i,
	input  logic       mem_ack_i
);

	z3_word_t   rd_data;
	z3_nibble_t cfg_rdata;
	logic       cfg_wr;
	logic       card_en;
	logic       cfg_allow;
	logic [`Z3_CARD_MATCH_BITS-1:0] base_hi;

	z3_cycle_if cyc_if ();

	// ----------------------------------------------------------
	z3_bus_sampler u_sampler (
		.clk         (clk),
		.nIORST      (nIORST),
		.nfcs_i      (nfcs_i),
		.doe_i       (doe_i),
		.nds_i       (nds_i),
		.fc_i        (fc_i),
		.ad_i        (ad_i),
		.a_i         (a_i),
		.sd_i        (sd_i),
		.base_hi_i   (base_hi),
		.card_en_i   (card_en),
		.cfg_allow_i (cfg_allow),
		.cyc         (cyc_if)
	);

	z3_slave_fsm u_fsm (
		.clk         (clk),
		.nIORST      (nIORST),
		.read_i      (read_i),
		.nfcs_i      (nfcs_i),
		.nberr_i     (nberr_i),
		.mem_ack_i   (mem_ack_i),
		.mem_rdata_i (mem_rdata_i),
		.cfg_rdata_i (cfg_rdata),
		.cyc         (cyc_if),
		.nslave_o    (nslave_o),
		.ndtack_o    (ndtack_o),
		.data_oe_o   (data_oe_o),
		.rd_data_o   (rd_data),
		.mem_stb_o   (mem_stb_o),
		.mem_we_o    (mem_we_o),
		.mem_addr_o  (mem_addr_o),
		.mem_wdata_o (mem_wdata_o),
		.mem_dqm_n_o (mem_dqm_n_o),
		.cfg_wr_o    (cfg_wr),
		.fault_o     (fault_o)
	);

	z3_autoconfig u_autoconfig (
		.clk         (clk),
		.nIORST      (nIORST),
		.ncfgin_i    (ncfgin_i),
		.cfg_wr_i    (cfg_wr),
		.read_i      (read_i),
		.cyc         (cyc_if),
		.cfg_rdata_o (cfg_rdata),
		.base_hi_o   (base_hi),
		.card_en_o   (card_en),
		.cfg_allow_o (cfg_allow),
		.ncfgout_o   (ncfgout_o)
	);

	// read word back onto the multiplexed lanes
	// D31..24 and D15..0 on AD, D23..16 on SD
	assign ad_o = {rd_data[31:24], rd_data[15:0]};
	assign sd_o = rd_data[23:16];

endmodule

/* z3sdram.f */
+incdir+source
source/z3_pkg.sv
source/z3_cycle_if.sv
source/z3_bus_sampler.sv
source/z3_slave_fsm.sv
source/z3_autoconfig.sv
source/z3sdram.sv
sim/z3sdram_props.sv
sim/z3sdram_tb.sv
